/* hdl/traffic_pkg.sv */
package traffic_pkg;

    // one phase of the signal head, stepped red -> green -> yellow -> red.
    typedef enum logic [1:0] {
        PHASE_RED    = 2'd0,
        PHASE_GREEN  = 2'd1,
        PHASE_YELLOW = 2'd2
    } phase_e;

    // lamp enables of the signal head itself.
    typedef struct packed {
        logic red;
        logic yellow;
        logic green;
    } lamp_t;

    // current phase and the seconds still left in it.
    typedef struct packed {
        phase_e     phase;
        logic [3:0] digit;
    } signal_state_t;

endpackage

/* hdl/matrix_pkg.sv */
package matrix_pkg;

    typedef logic [2:0] row_idx_t;

    // bit 7 drives the leftmost LED of a row.
    typedef logic [7:0] col_t;

    typedef struct packed {
        col_t colr;
        col_t colg;
    } row_pixels_t;

    // everything that goes to the matrix pins in one clock.
    typedef struct packed {
        logic [7:0]  row;
        row_pixels_t pixels;
    } matrix_out_t;

    // the glyph sits in rows 1 to 6, rows 0 and 7 stay dark.
    function automatic col_t digit_font(input logic [3:0] digit, input row_idx_t row);
        logic [47:0] glyph;
        case (digit)
            4'd0:    glyph = {8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h3C};
            4'd1:    glyph = {8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7E};
            4'd2:    glyph = {8'h3C, 8'h66, 8'h0C, 8'h18, 8'h30, 8'h7E};
            4'd3:    glyph = {8'h3C, 8'h66, 8'h0C, 8'h06, 8'h66, 8'h3C};
            4'd4:    glyph = {8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C};
            4'd5:    glyph = {8'h7E, 8'h60, 8'h7C, 8'h06, 8'h66, 8'h3C};
            4'd6:    glyph = {8'h3C, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C};
            4'd7:    glyph = {8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30};
            4'd8:    glyph = {8'h3C, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C};
            4'd9:    glyph = {8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h3C};
            default: glyph = '0;
        endcase
        if (row == 3'd0 || row == 3'd7)
        begin
            return '0;
        end
        return glyph[8 * (6 - int'(row)) +: 8];
    endfunction

endpackage

/* hdl/phase_sequencer.sv */
`timescale 1ns/100ps

module phase_sequencer
    import traffic_pkg::*;
#(
    parameter int TICK_DIV    = 1000,
    parameter int RED_TIME    = 9,
    parameter int GREEN_TIME  = 7,
    parameter int YELLOW_TIME = 3
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          pause,
    output signal_state_t state,
    output lamp_t         lamps
);

    localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic              sec_tick;
    signal_state_t     state_q;

    function automatic logic [3:0] phase_time(input phase_e p);
        case (p)
            PHASE_GREEN:  return GREEN_TIME[3:0];
            PHASE_YELLOW: return YELLOW_TIME[3:0];
            default:      return RED_TIME[3:0];
        endcase
    endfunction

    function automatic phase_e next_phase(input phase_e p);
        case (p)
            PHASE_RED:   return PHASE_GREEN;
            PHASE_GREEN: return PHASE_YELLOW;
            default:     return PHASE_RED;
        endcase
    endfunction

    // only unpaused cycles count toward a second.
    assign sec_tick = !pause && (tick_cnt == TICK_W'(TICK_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tick_cnt <= '0;
        else if (sec_tick)
            tick_cnt <= '0;
        else if (!pause)
            tick_cnt <= tick_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_q.phase <= PHASE_RED;
            state_q.digit <= RED_TIME[3:0];
        end
        else if (sec_tick)
        begin
            if (state_q.digit == 4'd1)
            begin
                state_q.phase <= next_phase(state_q.phase);
                state_q.digit <= phase_time(next_phase(state_q.phase));
            end
            else
                state_q.digit <= state_q.digit - 4'd1;
        end
    end

    assign state = state_q;

    always_comb
    begin
        lamps = '0;
        case (state_q.phase)
            PHASE_GREEN:  lamps.green  = 1'b1;
            PHASE_YELLOW: lamps.yellow = 1'b1;
            default:      lamps.red    = 1'b1;
        endcase
    end

endmodule

/* hdl/glyph_renderer.sv */
`timescale 1ns/100ps

module glyph_renderer
    import traffic_pkg::*;
    import matrix_pkg::*;
(
    input  signal_state_t state,
    input  row_idx_t      scan_row,
    output row_pixels_t   pixels
);

    col_t pattern;

    assign pattern = digit_font(state.digit, scan_row);

    // yellow has no LED of its own, it is red and green lit together.
    always_comb
    begin
        case (state.phase)
            PHASE_RED:
            begin
                pixels.colr = pattern;
                pixels.colg = '0;
            end
            PHASE_GREEN:
            begin
                pixels.colr = '0;
                pixels.colg = pattern;
            end
            PHASE_YELLOW:
            begin
                pixels.colr = pattern;
                pixels.colg = pattern;
            end
            default:
            begin
                pixels.colr = '0;
                pixels.colg = '0;
            end
        endcase
    end

endmodule

/* hdl/matrix_driver.sv */
`timescale 1ns/100ps

module matrix_driver
    import matrix_pkg::*;
#(
    parameter int SCAN_DIV = 1000
) (
    input  logic        clk,
    input  logic        rst,
    input  row_pixels_t pixels,
    output row_idx_t    scan_row,
    output matrix_out_t out
);

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic              row_step;
    row_idx_t          row_q;
    logic [7:0]        row_onehot;
    matrix_out_t       out_q;

    assign row_step = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else if (row_step)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // the row counter wraps from 7 back to 0 on its own.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_q <= '0;
        else if (row_step)
            row_q <= row_q + 3'd1;
    end

    assign scan_row   = row_q;
    assign row_onehot = 8'd1 << row_q;

    // row select and columns are captured on the same edge so the pins never disagree.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            out_q <= '0;
        else
        begin
            out_q.row    <= row_onehot;
            out_q.pixels <= pixels;
        end
    end

    assign out = out_q;

endmodule

/* hdl/traffic_matrix_top.sv */
`timescale 1ns/100ps

module traffic_matrix_top
    import traffic_pkg::*;
    import matrix_pkg::*;
#(
    parameter int TICK_DIV    = 1_000_000,
    parameter int RED_TIME    = 9,
    parameter int GREEN_TIME  = 7,
    parameter int YELLOW_TIME = 3,
    parameter int SCAN_DIV    = 1000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       pause,
    output lamp_t      lamps,
    output logic [7:0] row,
    output col_t       colr,
    output col_t       colg
);

    signal_state_t state;
    row_idx_t      scan_row;
    row_pixels_t   pixels;
    matrix_out_t   mat_out;

    phase_sequencer #(
        .TICK_DIV    (TICK_DIV),
        .RED_TIME    (RED_TIME),
        .GREEN_TIME  (GREEN_TIME),
        .YELLOW_TIME (YELLOW_TIME)
    ) u_sequencer (
        .clk   (clk),
        .rst   (rst),
        .pause (pause),
        .state (state),
        .lamps (lamps)
    );

    glyph_renderer u_renderer (
        .state    (state),
        .scan_row (scan_row),
        .pixels   (pixels)
    );

    matrix_driver #(
        .SCAN_DIV (SCAN_DIV)
    ) u_driver (
        .clk      (clk),
        .rst      (rst),
        .pixels   (pixels),
        .scan_row (scan_row),
        .out      (mat_out)
    );

    assign row  = mat_out.row;
    assign colr = mat_out.pixels.colr;
    assign colg = mat_out.pixels.colg;

endmodule

/* testbench/traffic_matrix_chk.sv */
`timescale 1ns/100ps

module traffic_matrix_chk
    import traffic_pkg::*;
    import matrix_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input lamp_t      lamps,
    input logic [7:0] row,
    input col_t       colr,
    input col_t       colg
);

    int fail_count = 0;

    lamps_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(lamps))
    else
    begin
        fail_count++;
        $error("lamp outputs are not one-hot");
    end

    row_onehot0: assert property (@(posedge clk) disable iff (rst) $onehot0(row))
    else
    begin
        fail_count++;
        $error("more than one matrix row is selected");
    end

    // columns stay dark while no row is driven.
    cols_dark: assert property (@(posedge clk) (row == 8'h00) |-> (colr == '0 && colg == '0))
    else
    begin
        fail_count++;
        $error("columns are lit with no row selected");
    end

endmodule

bind traffic_matrix_top traffic_matrix_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .lamps (lamps),
    .row   (row),
    .colr  (colr),
    .colg  (colg)
);

/* testbench/tb_traffic_matrix.sv */
`timescale 1ns/100ps

module tb_traffic_matrix
    import traffic_pkg::*;
    import matrix_pkg::*;
();

    localparam int TICK_DIV    = 6;
    localparam int SCAN_DIV    = 3;
    localparam int RED_TIME    = 4;
    localparam int GREEN_TIME  = 3;
    localparam int YELLOW_TIME = 2;
    localparam int MAX_CYCLES  = 1000;

    logic        clk;
    logic        rst;
    logic        pause;
    lamp_t       lamps;
    logic [7:0]  row;
    col_t        colr;
    col_t        colg;

    integer      seed;
    phase_e      m_phase;
    logic [3:0]  m_digit;
    int          m_tick;
    int          m_scan;
    int          m_row;
    int          light_cycles;
    int          run_len;
    lamp_t       prev_lamps;
    phase_e      prev_phase;
    logic        pause_seen;
    logic [7:0]  exp_row;
    row_pixels_t exp_pix;

    traffic_matrix_top #(
        .TICK_DIV    (TICK_DIV),
        .RED_TIME    (RED_TIME),
        .GREEN_TIME  (GREEN_TIME),
        .YELLOW_TIME (YELLOW_TIME),
        .SCAN_DIV    (SCAN_DIV)
    ) dut (
        .clk   (clk),
        .rst   (rst),
        .pause (pause),
        .lamps (lamps),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_lamps(input lamp_t exp, input lamp_t act);
        if (act !== exp)
            fail_stop($sformatf("mismatch lamps: expected 0x%h, actual 0x%h", exp, act));
    endtask

    task automatic check_row(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            fail_stop($sformatf("mismatch row: expected 0x%h, actual 0x%h", exp, act));
    endtask

    task automatic check_pixels(input row_pixels_t exp, input row_pixels_t act);
        if (act.colr !== exp.colr)
            fail_stop($sformatf("mismatch colr: expected 0x%h, actual 0x%h", exp.colr, act.colr));
        if (act.colg !== exp.colg)
            fail_stop($sformatf("mismatch colg: expected 0x%h, actual 0x%h", exp.colg, act.colg));
    endtask

    task automatic check_assertions();
        if (dut.u_chk.fail_count != 0)
            fail_stop("a bound assertion on the DUT outputs failed");
    endtask

    function automatic lamp_t lamp_of(input phase_e p);
        lamp_t l;
        l = '0;
        case (p)
            PHASE_GREEN:  l.green  = 1'b1;
            PHASE_YELLOW: l.yellow = 1'b1;
            default:      l.red    = 1'b1;
        endcase
        return l;
    endfunction

    function automatic int seconds_of(input phase_e p);
        case (p)
            PHASE_GREEN:  return GREEN_TIME;
            PHASE_YELLOW: return YELLOW_TIME;
            default:      return RED_TIME;
        endcase
    endfunction

    // red lights the red LEDs, green the green ones, yellow lights both.
    function automatic row_pixels_t render(input phase_e p, input logic [3:0] d, input int r);
        row_pixels_t px;
        col_t        glyph;
        glyph   = digit_font(d, row_idx_t'(r));
        px.colr = (p == PHASE_GREEN) ? '0 : glyph;
        px.colg = (p == PHASE_RED) ? '0 : glyph;
        return px;
    endfunction

    task automatic step_model(input logic p);
        if (!p)
        begin
            if (m_tick == TICK_DIV - 1)
            begin
                m_tick = 0;
                if (m_digit == 4'd1)
                begin
                    case (m_phase)
                        PHASE_RED:   m_phase = PHASE_GREEN;
                        PHASE_GREEN: m_phase = PHASE_YELLOW;
                        default:
                        begin
                            m_phase = PHASE_RED;
                            light_cycles++;
                        end
                    endcase
                    m_digit = 4'(seconds_of(m_phase));
                end
                else
                    m_digit = m_digit - 4'd1;
            end
            else
                m_tick++;
        end
        // the row scan runs regardless of pause.
        if (m_scan == SCAN_DIV - 1)
        begin
            m_scan = 0;
            m_row  = (m_row + 1) % 8;
        end
        else
            m_scan++;
    endtask

    task automatic check_reset_outputs();
        check_lamps(lamp_of(PHASE_RED), lamps);
        check_row(8'h00, row);
        check_pixels('0, {colr, colg});
        check_assertions();
    endtask

    initial
    begin
        seed         = 16846;
        rst          = 1'b1;
        pause        = 1'b0;
        m_phase      = PHASE_RED;
        m_digit      = 4'(RED_TIME);
        m_tick       = 0;
        m_scan       = 0;
        m_row        = 0;
        light_cycles = 0;
        run_len      = 0;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_reset_outputs();
        end
        #1;
        rst = 1'b0;
        #1;
        check_reset_outputs();
        prev_lamps = lamps;
        prev_phase = m_phase;
        for (int cycle = 0; cycle < MAX_CYCLES && light_cycles < 3; cycle++)
        begin
            @(posedge clk);
            // the output register takes the state and row from before this edge.
            pause_seen = pause;
            exp_row    = 8'd1 << m_row;
            exp_pix    = render(m_phase, m_digit, m_row);
            step_model(pause_seen);
            if (!pause_seen)
                run_len++;
            #1;
            check_lamps(lamp_of(m_phase), lamps);
            check_row(exp_row, row);
            check_pixels(exp_pix, {colr, colg});
            check_assertions();
            if (lamps != prev_lamps)
            begin
                if (run_len != seconds_of(prev_phase) * TICK_DIV)
                    fail_stop($sformatf("a phase lasted %0d unpaused cycles instead of %0d",
                        run_len, seconds_of(prev_phase) * TICK_DIV));
                run_len    = 0;
                prev_lamps = lamps;
                prev_phase = m_phase;
            end
            #1;
            pause = (($random(seed) & 3) == 0);
        end
        if (light_cycles < 3)
            fail_stop("timeout: the light did not finish three full cycles");
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* sources.f */
hdl/traffic_pkg.sv
hdl/matrix_pkg.sv
hdl/phase_sequencer.sv
hdl/glyph_renderer.sv
hdl/matrix_driver.sv
hdl/traffic_matrix_top.sv
testbench/traffic_matrix_chk.sv
testbench/tb_traffic_matrix.sv

/* Bender.yml */
package:
  name: traffic_matrix

sources:
  - files:
      - hdl/traffic_pkg.sv
      - hdl/matrix_pkg.sv
      - hdl/phase_sequencer.sv
      - hdl/glyph_renderer.sv
      - hdl/matrix_driver.sv
      - hdl/traffic_matrix_top.sv
  - target: test
    files:
      - testbench/traffic_matrix_chk.sv
      - testbench/tb_traffic_matrix.sv
